// File: design/debug_ring_params.svh
`ifndef DEBUG_RING_PARAMS_SVH
`define DEBUG_RING_PARAMS_SVH

// clock cycles per uart bit, small for simulation
`define DBG_BAUD_DIV 8

// number of nodes on the ring
`define DBG_NODES 4

// clock cycles per ring bit on every hop
`define DBG_HOP_PRESCALE 4

// node identity is this base plus the node index
`define DBG_ID_BASE 32'h11223300

`endif

// File: design/debug_ring_pkg.sv
package debug_ring_pkg;

    // ring command opcodes
    typedef enum logic [7:0] {
        OP_NOP     = 8'h00,
        OP_READ_ID = 8'h01,
        OP_WRITE   = 8'h02,
        OP_READ    = 8'h03
    } dbg_op_e;

    // frame as it travels the ring, address byte goes first
    typedef struct packed {
        logic [7:0]  addr;
        dbg_op_e     op;
        logic [31:0] data;
    } dbg_frame_t;

    localparam int FRAME_BITS = 48;

endpackage

// File: design/host_rx_bridge.sv
`include "debug_ring_params.svh"

module host_rx_bridge (
    input  logic clk,
    input  logic rst_n,
    input  logic uart_rx,
    output logic ring_data,
    output logic ring_strobe,
    output logic ring_start
);

    localparam int CW = $clog2(debug_ring_pkg::FRAME_BITS + 1);
    localparam int PW = $clog2(`DBG_HOP_PRESCALE + 1);
    localparam logic [15:0] HALF_LAST = 16'(`DBG_BAUD_DIV / 2 - 1);
    localparam logic [15:0] FULL_LAST = 16'(`DBG_BAUD_DIV - 1);
    localparam logic [PW-1:0] PRE_LAST = PW'(`DBG_HOP_PRESCALE - 1);
    localparam logic [CW-1:0] FRAME_LEN = CW'(debug_ring_pkg::FRAME_BITS);

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP,
        RX_SHIFT
    } rx_state_e;

    rx_state_e state;
    logic rx_meta;
    logic rx_sync;
    logic [15:0] baud_cnt;
    logic [2:0] bit_cnt;
    logic [2:0] byte_cnt;
    logic [7:0] rx_byte;
    logic [debug_ring_pkg::FRAME_BITS-1:0] frame_sr;
    logic [PW-1:0] pre_cnt;
    logic [CW-1:0] out_cnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= uart_rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= RX_IDLE;
            baud_cnt    <= '0;
            bit_cnt     <= '0;
            byte_cnt    <= '0;
            pre_cnt     <= '0;
            out_cnt     <= '0;
            ring_data   <= 1'b0;
            ring_strobe <= 1'b0;
            ring_start  <= 1'b0;
        end else begin
            ring_strobe <= 1'b0;
            ring_start  <= 1'b0;
            case (state)
                RX_IDLE: begin
                    if (!rx_sync) begin
                        state    <= RX_START;
                        baud_cnt <= '0;
                    end
                end
                RX_START: begin
                    // recheck the start bit at its middle
                    if (baud_cnt == HALF_LAST) begin
                        baud_cnt <= '0;
                        bit_cnt  <= '0;
                        state    <= rx_sync ? RX_IDLE : RX_DATA;
                    end else begin
                        baud_cnt <= baud_cnt + 16'd1;
                    end
                end
                RX_DATA: begin
                    if (baud_cnt == FULL_LAST) begin
                        baud_cnt <= '0;
                        rx_byte  <= {rx_sync, rx_byte[7:1]};
                        bit_cnt  <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 16'd1;
                    end
                end
                RX_STOP: begin
                    if (baud_cnt == FULL_LAST) begin
                        baud_cnt <= '0;
                        state    <= RX_IDLE;
                        // a byte with a bad stop bit is dropped
                        if (rx_sync) begin
                            frame_sr <= {frame_sr[39:0], rx_byte};
                            if (byte_cnt == 3'd5) begin
                                byte_cnt <= '0;
                                pre_cnt  <= '0;
                                out_cnt  <= '0;
                                state    <= RX_SHIFT;
                            end else begin
                                byte_cnt <= byte_cnt + 3'd1;
                            end
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 16'd1;
                    end
                end
                RX_SHIFT: begin
                    if (pre_cnt == '0) begin
                        ring_data   <= frame_sr[debug_ring_pkg::FRAME_BITS-1];
                        ring_strobe <= 1'b1;
                        ring_start  <= (out_cnt == '0);
                        frame_sr    <= {frame_sr[debug_ring_pkg::FRAME_BITS-2:0], 1'b0};
                        out_cnt     <= out_cnt + CW'(1);
                    end
                    if (pre_cnt == PRE_LAST) begin
                        pre_cnt <= '0;
                        if (out_cnt == FRAME_LEN) begin
                            state <= RX_IDLE;
                        end
                    end else begin
                        pre_cnt <= pre_cnt + PW'(1);
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // host must wait for the response before the next command
    a_no_rx_during_shift: assert property (
        @(posedge clk) disable iff (!rst_n) (state == RX_SHIFT) |-> !$fell(rx_sync));

endmodule

// File: design/debug_node.sv
`include "debug_ring_params.svh"

module debug_node #(
    parameter int NODE_INDEX = 0
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        in_data,
    input  logic        in_strobe,
    input  logic        in_start,
    output logic        out_data,
    output logic        out_strobe,
    output logic        out_start,
    output logic [31:0] debug_reg
);

    localparam int CW = $clog2(debug_ring_pkg::FRAME_BITS + 1);
    localparam int PW = $clog2(`DBG_HOP_PRESCALE + 1);
    localparam logic [PW-1:0] PRE_LAST = PW'(`DBG_HOP_PRESCALE - 1);
    localparam logic [CW-1:0] FRAME_LEN = CW'(debug_ring_pkg::FRAME_BITS);

    logic [debug_ring_pkg::FRAME_BITS-1:0] rx_sr;
    logic [debug_ring_pkg::FRAME_BITS-1:0] tx_sr;
    logic [CW-1:0] in_cnt;
    logic [CW-1:0] next_cnt;
    logic [CW-1:0] out_cnt;
    logic [PW-1:0] pre_cnt;
    logic rx_done;
    logic fwd;
    logic hit;
    debug_ring_pkg::dbg_frame_t rx_frame;
    debug_ring_pkg::dbg_frame_t tx_frame;

    // frame start restarts the bit count
    assign next_cnt = in_start ? CW'(1) : in_cnt + CW'(1);
    assign rx_frame = rx_sr;
    assign hit = (rx_frame.addr == 8'(NODE_INDEX));

    always_comb begin
        tx_frame = rx_frame;
        if (hit) begin
            case (rx_frame.op)
                debug_ring_pkg::OP_READ_ID: tx_frame.data = `DBG_ID_BASE + 32'(NODE_INDEX);
                debug_ring_pkg::OP_READ:    tx_frame.data = debug_reg;
                default:                    tx_frame.data = rx_frame.data;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (in_strobe) begin
            rx_sr <= {rx_sr[debug_ring_pkg::FRAME_BITS-2:0], in_data};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_cnt     <= '0;
            rx_done    <= 1'b0;
            fwd        <= 1'b0;
            pre_cnt    <= '0;
            out_cnt    <= '0;
            out_data   <= 1'b0;
            out_strobe <= 1'b0;
            out_start  <= 1'b0;
            debug_reg  <= '0;
        end else begin
            rx_done    <= 1'b0;
            out_strobe <= 1'b0;
            out_start  <= 1'b0;
            if (in_strobe) begin
                in_cnt  <= next_cnt;
                rx_done <= (next_cnt == FRAME_LEN);
            end
            if (rx_done) begin
                tx_sr   <= tx_frame;
                fwd     <= 1'b1;
                pre_cnt <= '0;
                out_cnt <= '0;
                if (hit && rx_frame.op == debug_ring_pkg::OP_WRITE) begin
                    debug_reg <= rx_frame.data;
                end
            end else if (fwd) begin
                if (pre_cnt == '0) begin
                    out_data   <= tx_sr[debug_ring_pkg::FRAME_BITS-1];
                    out_strobe <= 1'b1;
                    out_start  <= (out_cnt == '0);
                    tx_sr      <= {tx_sr[debug_ring_pkg::FRAME_BITS-2:0], 1'b0};
                    out_cnt    <= out_cnt + CW'(1);
                end
                if (pre_cnt == PRE_LAST) begin
                    pre_cnt <= '0;
                    if (out_cnt == FRAME_LEN) begin
                        fwd <= 1'b0;
                    end
                end else begin
                    pre_cnt <= pre_cnt + PW'(1);
                end
            end
        end
    end

    // upstream must not start a new frame before this one has left
    a_no_overrun: assert property (
        @(posedge clk) disable iff (!rst_n) fwd |-> !in_strobe);

    // the upstream hop raises frame start only together with its strobe
    a_start_with_strobe: assert property (
        @(posedge clk) disable iff (!rst_n) in_start |-> in_strobe);

endmodule

// File: design/host_tx_bridge.sv
`include "debug_ring_params.svh"

module host_tx_bridge (
    input  logic clk,
    input  logic rst_n,
    input  logic ring_data,
    input  logic ring_strobe,
    input  logic ring_start,
    output logic uart_tx
);

    localparam int CW = $clog2(debug_ring_pkg::FRAME_BITS + 1);
    localparam logic [15:0] FULL_LAST = 16'(`DBG_BAUD_DIV - 1);
    localparam logic [CW-1:0] FRAME_LEN = CW'(debug_ring_pkg::FRAME_BITS);

    typedef enum logic {
        TX_IDLE,
        TX_BYTE
    } tx_state_e;

    tx_state_e state;
    logic [debug_ring_pkg::FRAME_BITS-1:0] rx_sr;
    logic [debug_ring_pkg::FRAME_BITS-1:0] frame_sr;
    logic [CW-1:0] in_cnt;
    logic [CW-1:0] next_cnt;
    logic rx_done;
    logic [9:0] tx_bits;
    logic [15:0] baud_cnt;
    logic [3:0] bit_cnt;
    logic [2:0] byte_cnt;

    assign next_cnt = ring_start ? CW'(1) : in_cnt + CW'(1);

    always_ff @(posedge clk) begin
        if (ring_strobe) begin
            rx_sr <= {rx_sr[debug_ring_pkg::FRAME_BITS-2:0], ring_data};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= TX_IDLE;
            in_cnt   <= '0;
            rx_done  <= 1'b0;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            byte_cnt <= '0;
            uart_tx  <= 1'b1;
        end else begin
            rx_done <= 1'b0;
            if (ring_strobe) begin
                in_cnt  <= next_cnt;
                rx_done <= (next_cnt == FRAME_LEN);
            end
            case (state)
                TX_IDLE: begin
                    if (rx_done) begin
                        // stop, byte, start; shifted out lsb first
                        tx_bits  <= {1'b1, rx_sr[47:40], 1'b0};
                        frame_sr <= {rx_sr[39:0], 8'h00};
                        baud_cnt <= '0;
                        bit_cnt  <= '0;
                        byte_cnt <= '0;
                        state    <= TX_BYTE;
                    end
                end
                TX_BYTE: begin
                    if (baud_cnt == '0) begin
                        uart_tx <= tx_bits[0];
                        tx_bits <= {1'b1, tx_bits[9:1]};
                    end
                    if (baud_cnt == FULL_LAST) begin
                        baud_cnt <= '0;
                        bit_cnt  <= bit_cnt + 4'd1;
                        if (bit_cnt == 4'd9) begin
                            bit_cnt <= '0;
                            if (byte_cnt == 3'd5) begin
                                state <= TX_IDLE;
                            end else begin
                                byte_cnt <= byte_cnt + 3'd1;
                                tx_bits  <= {1'b1, frame_sr[47:40], 1'b0};
                                frame_sr <= {frame_sr[39:0], 8'h00};
                            end
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 16'd1;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // the whole response leaves before the ring delivers another frame
    a_no_strobe_while_sending: assert property (
        @(posedge clk) disable iff (!rst_n) (state == TX_BYTE) |-> !ring_strobe);

endmodule

// File: design/debug_ring_top.sv
`include "debug_ring_params.svh"

module debug_ring_top (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       uart_rx,
    output logic       uart_tx,
    output logic [3:0] led
);

    // hop i feeds node i, hop DBG_NODES feeds the tx bridge
    logic hop_data [`DBG_NODES + 1];
    logic hop_strobe [`DBG_NODES + 1];
    logic hop_start [`DBG_NODES + 1];
    logic [31:0] node_reg [`DBG_NODES];

    host_rx_bridge u_rx (
        .clk         (clk),
        .rst_n       (rst_n),
        .uart_rx     (uart_rx),
        .ring_data   (hop_data[0]),
        .ring_strobe (hop_strobe[0]),
        .ring_start  (hop_start[0])
    );

    for (genvar i = 0; i < `DBG_NODES; i++) begin : g_node
        debug_node #(
            .NODE_INDEX (i)
        ) u_node (
            .clk        (clk),
            .rst_n      (rst_n),
            .in_data    (hop_data[i]),
            .in_strobe  (hop_strobe[i]),
            .in_start   (hop_start[i]),
            .out_data   (hop_data[i+1]),
            .out_strobe (hop_strobe[i+1]),
            .out_start  (hop_start[i+1]),
            .debug_reg  (node_reg[i])
        );
    end

    host_tx_bridge u_tx (
        .clk         (clk),
        .rst_n       (rst_n),
        .ring_data   (hop_data[`DBG_NODES]),
        .ring_strobe (hop_strobe[`DBG_NODES]),
        .ring_start  (hop_start[`DBG_NODES]),
        .uart_tx     (uart_tx)
    );

    // leds are active low
    assign led = ~node_reg[0][3:0];

endmodule

// File: verif/tb_debug_ring.sv
`include "debug_ring_params.svh"

module tb_debug_ring;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int DIV = `DBG_BAUD_DIV;
    localparam int UART_FRAME_CYCLES = 60 * DIV;
    // every hop re-times the whole frame
    localparam int RING_CYCLES = (`DBG_NODES + 1) * (48 * `DBG_HOP_PRESCALE + 4);
    localparam int RESP_LIMIT = UART_FRAME_CYCLES + RING_CYCLES + 4 * DIV;
    localparam int CASE_CYCLES = 2 * UART_FRAME_CYCLES + RING_CYCLES + 16 * DIV;
    localparam int WATCHDOG_MARGIN = 2000;

    logic clk = 1'b0;
    logic rst_n;
    logic uart_rx;
    logic uart_tx;
    logic [3:0] led;

    logic [7:0] case_addr[$];
    logic [7:0] case_op[$];
    logic [31:0] case_data[$];
    logic [31:0] case_expect[$];
    logic [7:0] rx_bytes[$];

    int num_cases = 0;
    bit cases_loaded = 1'b0;
    bit aborted = 1'b0;
    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    logic [31:0] lfsr_state = 32'h782efe53;
    logic [3:0] led_model = 4'b1111;

    debug_ring_top dut0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .uart_rx (uart_rx),
        .uart_tx (uart_tx),
        .led     (led)
    );

    always #5 clk = ~clk;

    // galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    task automatic draw_bits(input int n, output int value);
        value = 0;
        for (int k = 0; k < n; k++) begin
            value = (value << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    task automatic load_cases();
        int fd;
        int code;
        int n;
        string line;
        logic [7:0] a;
        logic [7:0] o;
        logic [31:0] d;
        logic [31:0] e;
        fd = $fopen("verif/debug_ring_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open verif/debug_ring_cases.txt, no cases to run");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            if (code > 0 && line.getc(0) != "#") begin
                n = $sscanf(line, "%h %h %h %h", a, o, d, e);
                if (n == 4) begin
                    case_addr.push_back(a);
                    case_op.push_back(o);
                    case_data.push_back(d);
                    case_expect.push_back(e);
                end
            end
        end
        $fclose(fd);
        num_cases = case_addr.size();
        if (num_cases == 0) begin
            $display("the cases file holds no usable lines");
            errors++;
        end
    endtask

    // 8n1, lsb first, called on a rising edge
    task automatic send_byte(input logic [7:0] value);
        logic [9:0] bits;
        bits = {1'b1, value, 1'b0};
        for (int k = 0; k < 10; k++) begin
            uart_rx <= bits[k];
            repeat (DIV) @(posedge clk);
        end
    endtask

    task automatic check_idle(input int cycles);
        int bad;
        bad = 0;
        repeat (cycles) begin
            @(negedge clk);
            assert (uart_tx === 1'b1 && led === 4'b1111) else begin
                $display("Error at %0d ns: idle uart_tx %b led %b, expected 1 and 1111",
                         $time, uart_tx, led);
                bad++;
            end
        end
        errors += bad;
        tests_run++;
        if (bad != 0) begin
            tests_failed++;
        end
        $display("reset idle check: %s", (bad == 0) ? "ok" : "mismatch");
    endtask

    task automatic run_case(input int idx);
        logic [47:0] cmd;
        logic [47:0] resp;
        int gap;
        int waited;
        int errors_before;
        errors_before = errors;
        draw_bits(4, gap);
        repeat (gap * DIV + 1) @(posedge clk);
        cmd = {case_addr[idx], case_op[idx], case_data[idx]};
        for (int b = 5; b >= 0; b--) begin
            send_byte(cmd[b*8 +: 8]);
        end
        waited = 0;
        while (rx_bytes.size() < 6 && waited < RESP_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        tests_run++;
        if (rx_bytes.size() < 6) begin
            $display("case %0d: no complete response on uart_tx within %0d cycles",
                     idx, RESP_LIMIT);
            errors++;
            tests_failed++;
            aborted = 1'b1;
            return;
        end
        resp = '0;
        repeat (6) begin
            resp = {resp[39:0], rx_bytes.pop_front()};
        end
        assert (resp[47:40] == case_addr[idx] && resp[39:32] == case_op[idx]) else begin
            $display("Error at %0d ns: case %0d echoed addr %h op %h, sent %h %h",
                     $time, idx, resp[47:40], resp[39:32], case_addr[idx], case_op[idx]);
            errors++;
        end
        assert (resp[31:0] == case_expect[idx]) else begin
            $display("Error at %0d ns: case %0d data %h, expected %h",
                     $time, idx, resp[31:0], case_expect[idx]);
            errors++;
        end
        // leds follow node 0 only, active low
        if (case_addr[idx] == 8'h00 && case_op[idx] == debug_ring_pkg::OP_WRITE) begin
            led_model = ~case_data[idx][3:0];
        end
        @(negedge clk);
        assert (led === led_model) else begin
            $display("Error at %0d ns: case %0d led %b, expected %b",
                     $time, idx, led, led_model);
            errors++;
        end
        if (errors != errors_before) begin
            tests_failed++;
        end
        $display("case %0d: addr %h op %h data %h -> %h: %s", idx, case_addr[idx],
                 case_op[idx], case_data[idx], resp[31:0],
                 (errors == errors_before) ? "ok" : "mismatch");
    endtask

    initial begin : uart_monitor
        logic [7:0] value;
        forever begin
            @(negedge clk);
            if (uart_tx === 1'b0) begin
                repeat (DIV / 2 - 1) @(negedge clk);
                if (uart_tx === 1'b0) begin
                    for (int k = 0; k < 8; k++) begin
                        repeat (DIV) @(negedge clk);
                        value[k] = uart_tx;
                    end
                    repeat (DIV) @(negedge clk);
                    assert (uart_tx === 1'b1) else begin
                        $display("uart_tx byte %h ended without a stop bit at %0d ns",
                                 value, $time);
                        errors++;
                    end
                    rx_bytes.push_back(value);
                end
            end
        end
    end

    initial begin : watchdog
        int limit;
        wait (cases_loaded);
        limit = num_cases * CASE_CYCLES + WATCHDOG_MARGIN;
        repeat (limit) @(posedge clk);
        $display("watchdog: the run did not finish within %0d cycles", limit);
        $display("Something failed");
        $finish;
    end

    initial begin : main
        int idx;
        uart_rx = 1'b1;
        rst_n = 1'b0;
        load_cases();
        cases_loaded = 1'b1;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        check_idle(16);
        idx = 0;
        while (idx < num_cases && !aborted) begin
            run_case(idx);
            idx++;
        end
        tests_failed += num_cases - idx;
        $display("tests run %0d, failed %0d, not run %0d, errors %0d",
                 tests_run, tests_failed, num_cases - idx, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+design
design/debug_ring_pkg.sv
design/host_rx_bridge.sv
design/debug_node.sv
design/host_tx_bridge.sv
design/debug_ring_top.sv
verif/tb_debug_ring.sv

// File: run.sh
#!/bin/sh
# build the testbench with verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert -j 0 \
    -f project.f --top-module tb_debug_ring -Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/Vtb_debug_ring" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Something failed" "$LOG"; then
    exit 1
fi
if ! grep -q "Everything OK" "$LOG"; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0

// File: verif/debug_ring_cases.txt
# columns: addr op data expected_data, all hex
# op 00 nop, 01 read id, 02 write, 03 read
00 01 00000000 11223300
01 01 00000000 11223301
02 01 00000000 11223302
03 01 00000000 11223303
00 02 cafe1235 cafe1235
02 02 0badf00d 0badf00d
00 03 00000000 cafe1235
02 03 00000000 0badf00d
01 03 00000000 00000000
07 01 deadbeef deadbeef
01 00 12345678 12345678
03 02 5a5aa5a5 5a5aa5a5
00 03 00000000 cafe1235
02 03 ffffffff 0badf00d
